// File: sim.f
logic/pagerTypesPkg.sv
logic/axiLitePkg.sv
logic/pageTable.sv
logic/refClassifier.sv
logic/pageCheck.sv
logic/ptConfigPort.sv
logic/pager.sv
tests/pager_checker.sv
tests/pagerTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the testbench reports a clean run
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pagerTb -f sim.f -o simv \
  && ./obj_dir/simv | tee /dev/stderr | grep -Fqx "Finished with no errors" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: tests/pagerTb.sv
`default_nettype none

module pagerTb import pagerTypesPkg::*, axiLitePkg::*; ();

  // About 1000 cycles of tests, with ample margin
  localparam int cycleLimit = 4000;

  logic      clk;
  logic      reset;
  lookupReq  req;
  logic      reqValid;
  logic      respReady;
  logic      reqReady;
  lookupResp resp;
  logic      respValid;
  axiAw      aw;
  axiW       w;
  axiAr      ar;
  logic      bready;
  logic      rready;
  logic      awready;
  logic      wready;
  logic      arready;
  axiB       b;
  axiR       r;

  // Table model
  pageEntry    mEntry [256][2];
  logic        mBad [256][2];
  logic        mWritten [256][2];
  dirTag       mTag [256];
  logic        mValid [256];
  lookupReq    loaded [$];
  lookupResp   expQ [$];

  integer seed = 32'h8f17;
  int     errors = 0;
  int     checks = 0;
  int     testErrs = 0;
  int     testNum = 1;
  int     cycles = 0;

  pager #(.ptAddrWidth(8)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: run did not complete within %0d cycles", cycleLimit);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [7:0] hashIndex(lookupReq q);
    logic [7:0] idx;
    idx = q.vPage[8:1];
    idx[7] = q.vPage[8] ^ q.exec;
    return idx;
  endfunction

  function automatic logic modelHit(lookupReq q);
    logic [7:0] idx;
    idx = hashIndex(q);
    return mValid[idx] && (mTag[idx] == {q.user, q.vPage[12:9]});
  endfunction

  // Expected response straight from the fail priority rules
  function automatic lookupResp modelResp(lookupReq q);
    lookupResp  e;
    logic [7:0] idx;
    logic       h;
    pageEntry   ent;
    e = '0;
    e.code = none;
    idx = hashIndex(q);
    h = q.vPage[0];
    ent = mEntry[idx][h];
    if (q.illEntry) begin
      e.pageFail = 1'b1;
      e.code = illEntry;
    end else if (q.exec && !q.paged) begin
      if (q.testPrivate) begin
        e.pageFail = 1'b1;
        e.code = illEntry;
      end else begin
        e.ok = 1'b1;
        e.pPage = q.vPage;
      end
    end else if (!modelHit(q)) begin
      e.pageRefill = 1'b1;
      e.code = refill;
    end else if (mBad[idx][h]) begin
      e.pageFail = 1'b1;
      e.code = parityError;
    end else if (!ent.access) begin
      e.pageFail = 1'b1;
      e.code = noAccess;
    end else if (q.write && !ent.writable) begin
      e.pageFail = 1'b1;
      e.code = writeViolation;
    end else if (q.testPrivate && q.user && !ent.public) begin
      e.pageFail = 1'b1;
      e.code = privateViolation;
    end else begin
      e.ok = 1'b1;
      e.pPage = ent.page;
      e.cacheable = ent.cache;
      e.software = ent.software;
    end
    return e;
  endfunction

  // A hit on a half that was never written has no defined contents
  function automatic logic halfUnknown(lookupReq q);
    logic [7:0] idx;
    idx = hashIndex(q);
    if (q.illEntry || (q.exec && !q.paged)) begin
      return 1'b0;
    end
    return modelHit(q) && !mWritten[idx][q.vPage[0]];
  endfunction

  function automatic lookupReq mkReq(logic [12:0] vPage, logic user, logic exec,
                                     logic write, logic testPrivate);
    lookupReq q;
    q = '0;
    q.vPage = vPage;
    q.user = user;
    q.exec = exec;
    q.paged = 1'b1;
    q.write = write;
    q.testPrivate = testPrivate;
    return q;
  endfunction

  // Flags are access, public, writable, software, cache
  function automatic pageEntry mkEntry(logic [4:0] flags, logic [12:0] page);
    return {flags, page};
  endfunction

  function automatic lookupReq randomReq(logic afterClear);
    lookupReq   q;
    logic [31:0] rnd;
    int         k;
    do begin
      rnd = rand32();
      q = mkReq(rnd[12:0], !rnd[13], rnd[13], 1'b0, 1'b0);
      if (rnd[23:21] < 3'd5 && loaded.size() > 0) begin
        k = rand32() % loaded.size();
        q = loaded[k];
      end
      q.write = rnd[14];
      q.testPrivate = rnd[16:15] == 2'd0;
      q.illEntry = !afterClear && (rnd[20:17] == 4'd0);
      if (!afterClear && rnd[23:21] == 3'd7) begin
        q.exec = 1'b1;
        q.paged = 1'b0;
      end
    end while (halfUnknown(q));
    return q;
  endfunction

  task automatic checkVal(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
      testErrs++;
    end
  endtask

  task automatic endTest(string name);
    $display("Test %0d %s: %0d errors", testNum, name, testErrs);
    testNum++;
    testErrs = 0;
  endtask

  task automatic axiWrite(logic [11:0] addr, logic [31:0] data, axiResp expResp);
    logic fired;
    logic first;
    @(negedge clk);
    aw.addr = addr;
    aw.valid = 1'b1;
    w.data = data;
    w.strb = 4'hf;
    w.valid = 1'b1;
    fired = 1'b0;
    first = 1'b1;
    while (!fired) begin
      #5;
      if (first) begin
        // Nothing pending, so both readies answer straight away
        checkVal("awready", 32'(awready), 32'd1);
        checkVal("wready", 32'(wready), 32'd1);
        first = 1'b0;
      end
      fired = awready && wready;
      @(negedge clk);
    end
    aw.valid = 1'b0;
    w.valid = 1'b0;
    while (!b.valid) @(negedge clk);
    // Hold off one clock so the response has to wait
    @(negedge clk);
    bready = 1'b1;
    #5;
    checkVal("b.resp", 32'(b.resp), 32'(expResp));
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axiRead(logic [11:0] addr, logic [31:0] expData, axiResp expResp);
    logic fired;
    logic first;
    @(negedge clk);
    ar.addr = addr;
    ar.valid = 1'b1;
    fired = 1'b0;
    first = 1'b1;
    while (!fired) begin
      #5;
      if (first) begin
        checkVal("arready", 32'(arready), 32'd1);
        first = 1'b0;
      end
      fired = arready;
      @(negedge clk);
    end
    ar.valid = 1'b0;
    while (!r.valid) @(negedge clk);
    @(negedge clk);
    rready = 1'b1;
    #5;
    checkVal("r.data", r.data, expData);
    checkVal("r.resp", 32'(r.resp), 32'(expResp));
    // Held low while the read data waits
    checkVal("arready", 32'(arready), 32'd0);
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic storeEntry(logic [7:0] idx, logic h, pageEntry ent, dirTag tag, logic bad);
    axiWrite({1'b0, idx, h, 2'b00}, {bad, 8'd0, tag, ent}, okay);
    mEntry[idx][h] = ent;
    mBad[idx][h] = bad;
    mWritten[idx][h] = 1'b1;
    mTag[idx] = tag;
    mValid[idx] = 1'b1;
  endtask

  task automatic loadPage(lookupReq q, pageEntry ent, logic bad);
    storeEntry(hashIndex(q), q.vPage[0], ent, {q.user, q.vPage[12:9]}, bad);
    loaded.push_back(q);
  endtask

  task automatic clearDir();
    axiWrite(12'h800, 32'd0, okay);
    for (int i = 0; i < 256; i++) begin
      mValid[i] = 1'b0;
    end
  endtask

  task automatic lookupOne(lookupReq q, failCode expCode);
    lookupResp e;
    logic      fired;
    e = modelResp(q);
    @(negedge clk);
    req = q;
    reqValid = 1'b1;
    respReady = 1'b1;
    fired = 1'b0;
    while (!fired) begin
      #5;
      fired = reqReady;
      @(negedge clk);
    end
    reqValid = 1'b0;
    while (!respValid) @(negedge clk);
    #5;
    checkVal("resp", 32'(resp), 32'(e));
    checkVal("resp.code", 32'(resp.code), 32'(expCode));
  endtask

  // Back-to-back lookups against random response back-pressure
  task automatic lookupStream(int n, logic afterClear);
    int        issued;
    logic      accepted;
    logic [31:0] rnd;
    lookupResp e;
    issued = 0;
    accepted = 1'b0;
    expQ = {};
    while (issued < n || expQ.size() > 0) begin
      @(negedge clk);
      rnd = rand32();
      respReady = rnd[1:0] != 2'd0;
      if (accepted) begin
        reqValid = 1'b0;
      end
      if (!reqValid && issued < n && rnd[4:2] != 3'd0) begin
        req = randomReq(afterClear);
        reqValid = 1'b1;
      end
      #5;
      if (respValid && respReady) begin
        if (expQ.size() == 0) begin
          $display("Fail at %0t: response arrived with no lookup in flight", $time);
          errors++;
          testErrs++;
        end else begin
          e = expQ.pop_front();
          checkVal("resp", 32'(resp), 32'(e));
          if (afterClear) begin
            checkVal("resp.code", 32'(resp.code), 32'(refill));
          end
        end
      end
      accepted = reqValid && reqReady;
      if (accepted) begin
        expQ.push_back(modelResp(req));
        issued++;
      end
    end
    @(negedge clk);
    reqValid = 1'b0;
    respReady = 1'b1;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [7:0]  idx;
    logic        h;
    dirTag       tag;
    pageEntry    ent;
    lookupReq    q;
    for (int i = 0; i < 256; i++) begin
      mValid[i] = 1'b0;
      mWritten[i][0] = 1'b0;
      mWritten[i][1] = 1'b0;
    end
    reset = 1'b1;
    req = '0;
    reqValid = 1'b0;
    respReady = 1'b1;
    aw = '0;
    w = '0;
    ar = '0;
    bready = 1'b0;
    rready = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    #5;
    checkVal("reqReady", 32'(reqReady), 32'd1);
    checkVal("respValid", 32'(respValid), 32'd0);
    checkVal("b.valid", 32'(b.valid), 32'd0);
    checkVal("r.valid", 32'(r.valid), 32'd0);
    for (int i = 0; i < 4; i++) begin
      rnd = rand32();
      lookupOne(mkReq(rnd[12:0], 1'b1, 1'b0, 1'b0, 1'b0), refill);
    end
    endTest("reset state");

    for (int i = 0; i < 8; i++) begin
      rnd = rand32();
      idx = rnd[7:0];
      h = rnd[8];
      tag = rnd[13:9];
      rnd = rand32();
      ent = rnd[17:0];
      storeEntry(idx, h, ent, tag, 1'b0);
      axiRead({1'b0, idx, h, 2'b00}, {8'd0, 1'b1, tag, ent}, okay);
    end
    axiWrite(12'h900, 32'h1234, slverr);
    axiRead(12'h900, 32'd0, slverr);
    axiRead(12'h800, 32'd0, okay);
    endTest("write and readback");

    loadPage(mkReq(13'h102, 1'b1, 1'b0, 1'b0, 1'b0), mkEntry(5'b11101, 13'h0aa), 1'b0);
    loadPage(mkReq(13'h103, 1'b1, 1'b0, 1'b0, 1'b0), mkEntry(5'b11110, 13'h155), 1'b0);
    loadPage(mkReq(13'h010, 1'b0, 1'b1, 1'b0, 1'b0), mkEntry(5'b11001, 13'h777), 1'b0);
    loadPage(mkReq(13'h010, 1'b1, 1'b0, 1'b0, 1'b0), mkEntry(5'b11100, 13'h1234), 1'b0);
    loadPage(mkReq(13'h1e04, 1'b1, 1'b0, 1'b0, 1'b0), mkEntry(5'b10111, 13'h0f0f), 1'b0);
    lookupOne(mkReq(13'h102, 1'b1, 1'b0, 1'b0, 1'b0), none);
    lookupOne(mkReq(13'h103, 1'b1, 1'b0, 1'b0, 1'b0), none);
    lookupOne(mkReq(13'h010, 1'b0, 1'b1, 1'b0, 1'b0), none);
    lookupOne(mkReq(13'h010, 1'b1, 1'b0, 1'b0, 1'b0), none);
    lookupOne(mkReq(13'h1e04, 1'b1, 1'b0, 1'b0, 1'b0), none);
    // Exec flip lands on the user word, whose tag differs
    lookupOne(mkReq(13'h110, 1'b0, 1'b1, 1'b0, 1'b0), refill);
    endTest("translation");

    loadPage(mkReq(13'h040, 1'b1, 1'b0, 1'b0, 1'b0), mkEntry(5'b01100, 13'h0040), 1'b0);
    loadPage(mkReq(13'h042, 1'b1, 1'b0, 1'b0, 1'b0), mkEntry(5'b11000, 13'h0042), 1'b0);
    loadPage(mkReq(13'h044, 1'b1, 1'b0, 1'b0, 1'b0), mkEntry(5'b10100, 13'h0044), 1'b0);
    loadPage(mkReq(13'h046, 1'b1, 1'b0, 1'b0, 1'b0), mkEntry(5'b11100, 13'h0046), 1'b1);
    lookupOne(mkReq(13'h040, 1'b1, 1'b0, 1'b0, 1'b0), noAccess);
    lookupOne(mkReq(13'h042, 1'b1, 1'b0, 1'b1, 1'b0), writeViolation);
    lookupOne(mkReq(13'h042, 1'b1, 1'b0, 1'b0, 1'b0), none);
    lookupOne(mkReq(13'h044, 1'b1, 1'b0, 1'b0, 1'b1), privateViolation);
    q = mkReq(13'h044, 1'b1, 1'b0, 1'b0, 1'b0);
    q.illEntry = 1'b1;
    lookupOne(q, illEntry);
    lookupOne(mkReq(13'h244, 1'b1, 1'b0, 1'b0, 1'b0), refill);
    lookupOne(mkReq(13'h046, 1'b1, 1'b0, 1'b0, 1'b0), parityError);
    endTest("faults");

    for (int i = 0; i < 3; i++) begin
      rnd = rand32();
      q = mkReq(rnd[12:0], 1'b0, 1'b1, 1'b0, 1'b0);
      q.paged = 1'b0;
      lookupOne(q, none);
      q.testPrivate = 1'b1;
      lookupOne(q, illEntry);
    end
    endTest("unpaged exec");

    lookupStream(40, 1'b0);
    clearDir();
    lookupStream(12, 1'b1);
    endTest("random stream and clear");

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/pager_checker.sv
`default_nettype none

module pagerChecker import pagerTypesPkg::*, axiLitePkg::*; (
  input logic      clk,
  input logic      reset,
  input logic      reqValid,
  input logic      reqReady,
  input logic      respValid,
  input logic      respReady,
  input lookupResp resp,
  input logic      bready,
  input logic      rready,
  input axiB       b,
  input axiR       r
);

  // Held response must not move until taken
  respHold: assert property (@(posedge clk) disable iff (reset)
    respValid && !respReady |=> respValid && $stable(resp))
    else $error("Stalled lookup response changed before it was taken");

  bHold: assert property (@(posedge clk) disable iff (reset)
    b.valid && !bready |=> b.valid && $stable(b.resp))
    else $error("Write response dropped or changed before it was taken");

  rHold: assert property (@(posedge clk) disable iff (reset)
    r.valid && !rready |=> r.valid && $stable(r.data) && $stable(r.resp))
    else $error("Read response dropped or changed before it was taken");

  okOrFail: assert property (@(posedge clk) disable iff (reset)
    !(respValid && resp.ok && resp.pageFail))
    else $error("Lookup response flagged both ok and page fail");

  // Accepted, then no stall on the following clock
  twoClock: assert property (@(posedge clk) disable iff (reset)
    $past(reqValid && reqReady) && reqReady |=> respValid)
    else $error("Lookup response missing two clocks after acceptance");

endmodule

bind pager pagerChecker checker0 (
  .clk(clk), .reset(reset), .reqValid(reqValid), .reqReady(reqReady),
  .respValid(respValid), .respReady(respReady), .resp(resp),
  .bready(bready), .rready(rready), .b(b), .r(r)
);

`default_nettype wire

// File: logic/pager.sv
`default_nettype none

module pager import pagerTypesPkg::*, axiLitePkg::*; #(
  parameter int ptAddrWidth = 8
) (
  input  logic      clk,
  input  logic      reset,
  input  lookupReq  req,
  input  logic      reqValid,
  input  logic      respReady,
  output logic      reqReady,
  output lookupResp resp,
  output logic      respValid,
  input  axiAw      aw,
  input  axiW       w,
  input  axiAr      ar,
  input  logic      bready,
  input  logic      rready,
  output logic      awready,
  output logic      wready,
  output logic      arready,
  output axiB       b,
  output axiR       r
);

  logic                   advance;
  logic                   stage1Valid;
  logic [ptAddrWidth-1:0] rdIndex;
  logic                   rdHalf;
  dirTag                  rdTag;
  tableResult             tblResult;
  refClass                cls;
  logic                   wrEn;
  logic [ptAddrWidth-1:0] wrIndex;
  logic                   wrHalf;
  pageEntry               wrEntry;
  dirTag                  wrTag;
  logic                   wrBadParity;
  logic                   dirClear;
  logic [ptAddrWidth-1:0] cfgIndex;
  logic                   cfgHalf;
  pageEntry               cfgEntry;
  dirTag                  cfgTag;
  logic                   cfgValid;

  // Both stages freeze while a response sits untaken
  assign advance = !(respValid && !respReady);
  assign reqReady = advance;

  // Table hash, exec space flips the top index bit
  always_comb begin
    rdIndex = req.vPage[ptAddrWidth:1];
    rdIndex[ptAddrWidth-1] = req.vPage[ptAddrWidth] ^ req.exec;
    rdHalf = req.vPage[0];
    rdTag = '{user: req.user, vHigh: req.vPage[12:9]};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage1Valid <= 1'b0;
    end else if (advance) begin
      stage1Valid <= reqValid;
    end
  end

  pageTable #(.ptAddrWidth(ptAddrWidth)) table0 (
    .clk(clk), .reset(reset),
    .rdEn(advance), .rdIndex(rdIndex), .rdHalf(rdHalf), .rdTag(rdTag),
    .wrEn(wrEn), .wrIndex(wrIndex), .wrHalf(wrHalf), .wrEntry(wrEntry),
    .wrTag(wrTag), .wrBadParity(wrBadParity), .dirClear(dirClear),
    .cfgIndex(cfgIndex), .cfgHalf(cfgHalf),
    .cfgEntry(cfgEntry), .cfgTag(cfgTag), .cfgValid(cfgValid),
    .result(tblResult)
  );

  refClassifier classify (
    .clk(clk), .reset(reset), .advance(advance),
    .req(req), .cls(cls)
  );

  pageCheck check (
    .clk(clk), .reset(reset), .advance(advance),
    .tbl(tblResult), .cls(cls), .stage1Valid(stage1Valid),
    .respReady(respReady), .resp(resp), .respValid(respValid)
  );

  ptConfigPort #(.ptAddrWidth(ptAddrWidth)) config0 (
    .clk(clk), .reset(reset),
    .aw(aw), .w(w), .ar(ar), .bready(bready), .rready(rready),
    .awready(awready), .wready(wready), .arready(arready), .b(b), .r(r),
    .wrEn(wrEn), .wrIndex(wrIndex), .wrHalf(wrHalf), .wrEntry(wrEntry),
    .wrTag(wrTag), .wrBadParity(wrBadParity), .dirClear(dirClear),
    .cfgIndex(cfgIndex), .cfgHalf(cfgHalf),
    .cfgEntry(cfgEntry), .cfgTag(cfgTag), .cfgValid(cfgValid)
  );

endmodule

`default_nettype wire

// File: logic/ptConfigPort.sv
`default_nettype none

module ptConfigPort import pagerTypesPkg::*, axiLitePkg::*; #(
  parameter int ptAddrWidth = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  axiAw                   aw,
  input  axiW                    w,
  input  axiAr                   ar,
  input  logic                   bready,
  input  logic                   rready,
  output logic                   awready,
  output logic                   wready,
  output logic                   arready,
  output axiB                    b,
  output axiR                    r,
  output logic                   wrEn,
  output logic [ptAddrWidth-1:0] wrIndex,
  output logic                   wrHalf,
  output pageEntry               wrEntry,
  output dirTag                  wrTag,
  output logic                   wrBadParity,
  output logic                   dirClear,
  output logic [ptAddrWidth-1:0] cfgIndex,
  output logic                   cfgHalf,
  input  pageEntry               cfgEntry,
  input  dirTag                  cfgTag,
  input  logic                   cfgValid
);

  localparam logic [11:0] ctrlAddr = 12'(1 << (ptAddrWidth + 3));

  logic                   wrFire;
  logic                   wrIsEntry;
  logic                   wrIsCtrl;
  logic                   rdFire;
  logic                   rdIsEntry;
  logic                   rdIsCtrl;
  logic                   bValid;
  axiResp                 bResp;
  logic                   rValid;
  axiResp                 rResp;
  logic                   rdIsEntryQ;
  logic [ptAddrWidth-1:0] rdIndexQ;
  logic                   rdHalfQ;

  // Write channel, address and data taken together
  assign wrIsEntry = (aw.addr >> (ptAddrWidth + 3)) == 12'd0;
  assign wrIsCtrl = aw.addr == ctrlAddr;
  assign wrFire = aw.valid && w.valid && !bValid;
  assign awready = wrFire;
  assign wready = wrFire;

  assign wrEn = wrFire && wrIsEntry && (w.strb != 4'd0);
  assign dirClear = wrFire && wrIsCtrl && (w.strb != 4'd0);
  assign wrIndex = aw.addr[ptAddrWidth+2:3];
  assign wrHalf = aw.addr[2];
  assign wrEntry = w.data[17:0];
  assign wrTag = w.data[22:18];
  assign wrBadParity = w.data[31];

  always_ff @(posedge clk) begin
    if (reset) begin
      bValid <= 1'b0;
    end else if (wrFire) begin
      bValid <= 1'b1;
    end else if (bready) begin
      bValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wrFire) begin
      if (wrIsEntry || wrIsCtrl) begin
        bResp <= okay;
      end else begin
        bResp <= slverr;
      end
    end
  end

  assign b = '{resp: bResp, valid: bValid};

  // Read channel
  assign rdIsEntry = (ar.addr >> (ptAddrWidth + 3)) == 12'd0;
  assign rdIsCtrl = ar.addr == ctrlAddr;
  assign rdFire = ar.valid && !rValid;
  assign arready = !rValid;

  // Held address keeps the table readback steady while R waits
  assign cfgIndex = rValid ? rdIndexQ : ar.addr[ptAddrWidth+2:3];
  assign cfgHalf = rValid ? rdHalfQ : ar.addr[2];

  always_ff @(posedge clk) begin
    if (reset) begin
      rValid <= 1'b0;
    end else if (rdFire) begin
      rValid <= 1'b1;
    end else if (rready) begin
      rValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rdFire) begin
      rdIsEntryQ <= rdIsEntry;
      rdIndexQ <= ar.addr[ptAddrWidth+2:3];
      rdHalfQ <= ar.addr[2];
      if (rdIsEntry || rdIsCtrl) begin
        rResp <= okay;
      end else begin
        rResp <= slverr;
      end
    end
  end

  assign r = '{
    data: rdIsEntryQ ? {8'd0, cfgValid, cfgTag, cfgEntry} : 32'd0,
    resp: rResp,
    valid: rValid
  };

endmodule

`default_nettype wire

// File: logic/pageCheck.sv
`default_nettype none

module pageCheck import pagerTypesPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       advance,
  input  tableResult tbl,
  input  refClass    cls,
  input  logic       stage1Valid,
  input  logic       respReady,
  output lookupResp  resp,
  output logic       respValid
);

  lookupResp respNext;
  logic      load;

  assign load = advance && stage1Valid;

  // Fail priority, first match wins
  always_comb begin
    respNext = '0;
    respNext.code = none;
    if (cls.illEntry) begin
      respNext.pageFail = 1'b1;
      respNext.code = illEntry;
    end else if (cls.unpagedExec) begin
      if (cls.testPrivate) begin
        respNext.pageFail = 1'b1;
        respNext.code = illEntry;
      end else begin
        respNext.ok = 1'b1;
        respNext.pPage = cls.vPage;
      end
    end else if (!tbl.match) begin
      respNext.pageRefill = 1'b1;
      respNext.code = refill;
    end else if (!tbl.parityOk) begin
      respNext.pageFail = 1'b1;
      respNext.code = parityError;
    end else if (!tbl.entry.access) begin
      respNext.pageFail = 1'b1;
      respNext.code = noAccess;
    end else if (cls.write && !tbl.entry.writable) begin
      respNext.pageFail = 1'b1;
      respNext.code = writeViolation;
    end else if (cls.testPrivate && cls.userPagedRef && !tbl.entry.public) begin
      respNext.pageFail = 1'b1;
      respNext.code = privateViolation;
    end else begin
      respNext.ok = 1'b1;
      respNext.pPage = tbl.entry.page;
      respNext.cacheable = tbl.entry.cache;
      respNext.software = tbl.entry.software;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      respValid <= 1'b0;
    end else if (load) begin
      respValid <= 1'b1;
    end else if (respReady) begin
      respValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      resp <= respNext;
    end
  end

endmodule

`default_nettype wire

// File: logic/refClassifier.sv
`default_nettype none

module refClassifier import pagerTypesPkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     advance,
  input  lookupReq req,
  output refClass  cls
);

  refClass clsNext;

  always_comb begin
    clsNext.vPage = req.vPage;
    clsNext.execPagedRef = req.exec && req.paged && !req.illEntry;
    // User space is always mapped
    clsNext.userPagedRef = req.user && !req.illEntry;
    clsNext.unpagedExec = req.exec && !req.paged;
    clsNext.pagedRef = clsNext.execPagedRef || clsNext.userPagedRef;
    clsNext.write = req.write;
    clsNext.testPrivate = req.testPrivate;
    clsNext.illEntry = req.illEntry;
  end

  // Same enable as the table read so both land in stage one together
  always_ff @(posedge clk) begin
    if (reset) begin
      cls <= '0;
    end else if (advance) begin
      cls <= clsNext;
    end
  end

endmodule

`default_nettype wire

// File: logic/pageTable.sv
`default_nettype none

module pageTable import pagerTypesPkg::*; #(
  parameter int ptAddrWidth = 8
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   rdEn,
  input  logic [ptAddrWidth-1:0] rdIndex,
  input  logic                   rdHalf,
  input  dirTag                  rdTag,
  input  logic                   wrEn,
  input  logic [ptAddrWidth-1:0] wrIndex,
  input  logic                   wrHalf,
  input  pageEntry               wrEntry,
  input  dirTag                  wrTag,
  input  logic                   wrBadParity,
  input  logic                   dirClear,
  input  logic [ptAddrWidth-1:0] cfgIndex,
  input  logic                   cfgHalf,
  output pageEntry               cfgEntry,
  output dirTag                  cfgTag,
  output logic                   cfgValid,
  output tableResult             result
);

  localparam int depth = 1 << ptAddrWidth;

  ptWord            ptMem [depth];
  // Bit 1 guards the left half, bit 0 the right
  logic [1:0]       ptParity [depth];
  dirTag            ptDir [depth];
  logic [depth-1:0] ptValid;

  ptWord       wrWord;
  logic [35:0] halfMask;
  logic        wrPar;
  ptWord       rdWord;
  pageEntry    rdEntry;
  logic        rdPar;

  // Entry copied to both halves, mask keeps the other half intact
  always_comb begin
    wrWord.halves.left = wrEntry;
    wrWord.halves.right = wrEntry;
    halfMask = wrHalf ? {18'd0, {18{1'b1}}} : {{18{1'b1}}, 18'd0};
  end

  // Odd weight over entry plus parity, unless a bad one is asked for
  assign wrPar = ~(^wrEntry) ^ wrBadParity;

  always_ff @(posedge clk) begin
    if (wrEn) begin
      ptMem[wrIndex].raw <= (ptMem[wrIndex].raw & ~halfMask) | (wrWord.raw & halfMask);
      if (wrHalf) begin
        ptParity[wrIndex][0] <= wrPar;
      end else begin
        ptParity[wrIndex][1] <= wrPar;
      end
      ptDir[wrIndex] <= wrTag;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || dirClear) begin
      ptValid <= '0;
    end else if (wrEn) begin
      ptValid[wrIndex] <= 1'b1;
    end
  end

  // Lookup port
  assign rdWord = ptMem[rdIndex];
  assign rdEntry = rdHalf ? rdWord.halves.right : rdWord.halves.left;
  assign rdPar = rdHalf ? ptParity[rdIndex][0] : ptParity[rdIndex][1];

  always_ff @(posedge clk) begin
    if (rdEn) begin
      result.entry <= rdEntry;
      result.match <= ptValid[rdIndex] && (ptDir[rdIndex] == rdTag);
      result.parityOk <= ^{rdEntry, rdPar};
    end
  end

  // Readback port for the AXI side
  always_ff @(posedge clk) begin
    if (cfgHalf) begin
      cfgEntry <= ptMem[cfgIndex].halves.right;
    end else begin
      cfgEntry <= ptMem[cfgIndex].halves.left;
    end
    cfgTag <= ptDir[cfgIndex];
    cfgValid <= ptValid[cfgIndex];
  end

endmodule

`default_nettype wire

// File: logic/axiLitePkg.sv
`default_nettype none

package axiLitePkg;

  typedef enum logic [1:0] {
    okay   = 2'b00,
    slverr = 2'b10
  } axiResp;

  typedef struct packed {
    logic [11:0] addr;
    logic        valid;
  } axiAw;

  typedef struct packed {
    logic [11:0] addr;
    logic        valid;
  } axiAr;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
    logic        valid;
  } axiW;

  typedef struct packed {
    axiResp resp;
    logic   valid;
  } axiB;

  typedef struct packed {
    logic [31:0] data;
    axiResp      resp;
    logic        valid;
  } axiR;

endpackage

`default_nettype wire

// File: logic/pagerTypesPkg.sv
`default_nettype none

package pagerTypesPkg;

  // Half-word page table entry, flags above the physical page
  typedef struct packed {
    logic        access;
    logic        public;
    logic        writable;
    logic        software;
    logic        cache;
    logic [12:0] page;
  } pageEntry;

  // One table word, seen whole or as its two halves
  typedef union packed {
    logic [35:0] raw;
    struct packed {
      pageEntry left;
      pageEntry right;
    } halves;
  } ptWord;

  typedef struct packed {
    logic       user;
    logic [3:0] vHigh;
  } dirTag;

  typedef struct packed {
    logic [12:0] vPage;
    logic        user;
    logic        exec;
    logic        paged;
    logic        write;
    logic        testPrivate;
    logic        illEntry;
  } lookupReq;

  typedef struct packed {
    // Virtual page rides along for unpaged exec references
    logic [12:0] vPage;
    logic        execPagedRef;
    logic        userPagedRef;
    logic        unpagedExec;
    logic        pagedRef;
    logic        write;
    logic        testPrivate;
    logic        illEntry;
  } refClass;

  typedef struct packed {
    pageEntry entry;
    logic     match;
    logic     parityOk;
  } tableResult;

  typedef enum logic [2:0] {
    none,
    illEntry,
    noAccess,
    writeViolation,
    privateViolation,
    parityError,
    refill
  } failCode;

  typedef struct packed {
    logic [12:0] pPage;
    logic        ok;
    logic        pageFail;
    logic        pageRefill;
    failCode     code;
    logic        cacheable;
    logic        software;
  } lookupResp;

endpackage

`default_nettype wire
